// ==== axi_mem_pkg.sv ====
// Shared definitions for the single-port AXI4 memory slave.
// Holds the bus widths, the response codes and the packed payload
// structs of the five AXI channels. Every design file and the
// testbench take their channel types from here.

`default_nettype none

package axi_mem_pkg;

	// bus widths
	localparam int id_w   = 4;
	localparam int addr_w = 32;
	localparam int data_w = 64;
	localparam int strb_w = data_w / 8;

	typedef logic [1:0] resp_t;

	// AXI response codes
	localparam resp_t resp_okay   = 2'b00;
	localparam resp_t resp_slverr = 2'b10;
	localparam resp_t resp_decerr = 2'b11;

	// write address
	typedef struct packed {
		logic [id_w-1:0]   id;
		logic [addr_w-1:0] addr;
		logic [7:0]        len;
		logic [2:0]        size;
		logic [1:0]        burst;
	} aw_req_t;

	// write data, a single beat
	typedef struct packed {
		logic [data_w-1:0] data;
		logic [strb_w-1:0] strb;
		logic              last;
	} w_beat_t;

	// write response
	typedef struct packed {
		logic [id_w-1:0] id;
		resp_t           resp;
	} b_resp_t;

	// read address, same layout as the write address
	typedef struct packed {
		logic [id_w-1:0]   id;
		logic [addr_w-1:0] addr;
		logic [7:0]        len;
		logic [2:0]        size;
		logic [1:0]        burst;
	} ar_req_t;

	// read data, last is always set since there are no bursts
	typedef struct packed {
		logic [id_w-1:0]   id;
		logic [data_w-1:0] data;
		resp_t             resp;
		logic              last;
	} r_beat_t;

endpackage

`default_nettype wire

// ==== axi_mem_wait.sv ====
// Wait-state timer for one memory access.
// A one-cycle start pulse loads the count with wait_cycles. The count
// then runs down, and done rises in the cycle after it reaches zero.
// done holds until the next start, so the FSM can use it as a level.

`timescale 1ns/10ps
`default_nettype none

module axi_mem_wait #(
	parameter int wait_cycles = 2
) (
	input  logic clk,
	input  logic arst_n,
	input  logic start,
	output logic done
);

	localparam int cnt_w = (wait_cycles > 0) ? $clog2(wait_cycles + 1) : 1;

	logic [cnt_w-1:0] count;
	logic             running;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count   <= '0;
			running <= 1'b0;
			done    <= 1'b0;
		end else if (start) begin
			count   <= cnt_w'(wait_cycles);
			running <= 1'b1;
			done    <= 1'b0;
		end else if (running) begin
			if (count == '0) begin
				running <= 1'b0;
				done    <= 1'b1;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== axi_mem_array.sv ====
// Word storage behind the AXI memory slave.
// One write port with byte strobes and one registered read port.
// A read and a write to the same word in one cycle return the old
// word. The storage has no reset; its contents are unknown until
// written.

`timescale 1ns/10ps
`default_nettype none

module axi_mem_array #(
	parameter int mem_words = 1024
) (
	input  logic                              clk,
	input  logic                              wr_en,
	input  logic [$clog2(mem_words)-1:0]      wr_idx,
	input  logic [axi_mem_pkg::data_w-1:0]    wr_data,
	input  logic [axi_mem_pkg::strb_w-1:0]    wr_strb,
	input  logic                              rd_en,
	input  logic [$clog2(mem_words)-1:0]      rd_idx,
	output logic [axi_mem_pkg::data_w-1:0]    rd_data
);
	import axi_mem_pkg::*;

	logic [data_w-1:0] mem [mem_words];

	// byte-lane write
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int i = 0; i < strb_w; i++) begin
				if (wr_strb[i]) begin
					mem[wr_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
				end
			end
		end
	end

	// registered read, holds its word until the next rd_en
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_idx];
		end
	end

endmodule

`default_nettype wire

// ==== axi_mem_fsm.sv ====
// Write and read channel control of the AXI memory slave.
// The write side takes aw and w on the same edge, writes the array at
// once and answers on b after the wait timer ends. The read side reads
// the array at the accepting edge and answers on r after its own
// timer. Each request is checked: a burst gives SLVERR, an address
// past the memory gives DECERR, and only OKAY requests touch memory.

`timescale 1ns/10ps
`default_nettype none

module axi_mem_fsm #(
	parameter int mem_words = 1024
) (
	input  logic                             clk,
	input  logic                             arst_n,

	input  logic                             aw_valid,
	output logic                             aw_ready,
	input  axi_mem_pkg::aw_req_t             aw,

	input  logic                             w_valid,
	output logic                             w_ready,
	input  axi_mem_pkg::w_beat_t             w,

	output logic                             b_valid,
	input  logic                             b_ready,
	output axi_mem_pkg::b_resp_t             b,

	input  logic                             ar_valid,
	output logic                             ar_ready,
	input  axi_mem_pkg::ar_req_t             ar,

	output logic                             r_valid,
	input  logic                             r_ready,
	output axi_mem_pkg::r_beat_t             r,

	output logic                             wr_start,
	input  logic                             wr_done,
	output logic                             rd_start,
	input  logic                             rd_done,

	output logic                             wr_en,
	output logic [$clog2(mem_words)-1:0]     wr_idx,
	output logic [axi_mem_pkg::data_w-1:0]   wr_data,
	output logic [axi_mem_pkg::strb_w-1:0]   wr_strb,
	output logic                             rd_en,
	output logic [$clog2(mem_words)-1:0]     rd_idx,
	input  logic [axi_mem_pkg::data_w-1:0]   rd_data
);
	import axi_mem_pkg::*;

	localparam int idx_w    = $clog2(mem_words);
	localparam int word_lsb = $clog2(strb_w);

	typedef enum logic {
		wr_idle,
		wr_resp
	} wr_state_t;

	typedef enum logic {
		rd_idle,
		rd_busy
	} rd_state_t;

	wr_state_t wr_state;
	rd_state_t rd_state;
	logic      wr_accept;
	logic      rd_accept;
	resp_t     wr_check;
	resp_t     rd_check;
	b_resp_t   b_q;
	r_beat_t   r_q;

	// SLVERR takes priority over DECERR
	function automatic resp_t check_req(input logic [7:0] len, input logic [addr_w-1:0] addr);
		logic [addr_w-word_lsb-1:0] word;
		word = addr[addr_w-1:word_lsb];
		if (len != 8'd0) begin
			return resp_slverr;
		end
		if (word >= mem_words) begin
			return resp_decerr;
		end
		return resp_okay;
	endfunction

	// write channel

	assign wr_accept = (wr_state == wr_idle) && aw_valid && w_valid;
	assign aw_ready  = wr_accept;
	assign w_ready   = wr_accept;
	assign wr_check  = check_req(aw.len, aw.addr);

	assign wr_start = wr_accept;
	assign wr_en    = wr_accept && (wr_check == resp_okay);
	assign wr_idx   = aw.addr[word_lsb +: idx_w];
	assign wr_data  = w.data;
	assign wr_strb  = w.strb;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_state <= wr_idle;
		end else begin
			case (wr_state)
				wr_idle: begin
					if (wr_accept) begin
						wr_state <= wr_resp;
					end
				end
				wr_resp: begin
					if (b_valid && b_ready) begin
						wr_state <= wr_idle;
					end
				end
				default: begin
					wr_state <= wr_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_accept) begin
			b_q.id   <= aw.id;
			b_q.resp <= wr_check;
		end
	end

	assign b_valid = (wr_state == wr_resp) && wr_done;
	assign b       = b_q;

	// read channel

	assign ar_ready  = (rd_state == rd_idle);
	assign rd_accept = ar_ready && ar_valid;
	assign rd_check  = check_req(ar.len, ar.addr);

	assign rd_start = rd_accept;
	assign rd_en    = rd_accept && (rd_check == resp_okay);
	assign rd_idx   = ar.addr[word_lsb +: idx_w];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_state <= rd_idle;
		end else begin
			case (rd_state)
				rd_idle: begin
					if (rd_accept) begin
						rd_state <= rd_busy;
					end
				end
				rd_busy: begin
					if (r_valid && r_ready) begin
						rd_state <= rd_idle;
					end
				end
				default: begin
					rd_state <= rd_idle;
				end
			endcase
		end
	end

	// data follows the array until the timer ends, then freezes
	always_ff @(posedge clk) begin
		if (rd_accept) begin
			r_q.id   <= ar.id;
			r_q.resp <= rd_check;
			r_q.last <= 1'b1;
		end else if (rd_state == rd_busy && !rd_done) begin
			r_q.data <= (r_q.resp == resp_okay) ? rd_data : '0;
		end
	end

	assign r_valid = (rd_state == rd_busy) && rd_done;
	assign r       = r_q;

endmodule

`default_nettype wire

// ==== axi_mem_slave.sv ====
// Single-port AXI4 memory slave, single-beat 64-bit transfers.
// Connects the channel FSM, one wait timer per channel and the word
// array. mem_words sets the depth in words and wait_cycles the number
// of wait states added to every response.

`timescale 1ns/10ps
`default_nettype none

module axi_mem_slave #(
	parameter int mem_words   = 1024,
	parameter int wait_cycles = 2
) (
	input  logic                 clk,
	input  logic                 arst_n,

	input  logic                 aw_valid,
	output logic                 aw_ready,
	input  axi_mem_pkg::aw_req_t aw,

	input  logic                 w_valid,
	output logic                 w_ready,
	input  axi_mem_pkg::w_beat_t w,

	output logic                 b_valid,
	input  logic                 b_ready,
	output axi_mem_pkg::b_resp_t b,

	input  logic                 ar_valid,
	output logic                 ar_ready,
	input  axi_mem_pkg::ar_req_t ar,

	output logic                 r_valid,
	input  logic                 r_ready,
	output axi_mem_pkg::r_beat_t r
);
	import axi_mem_pkg::*;

	localparam int idx_w = $clog2(mem_words);

	logic              wr_start;
	logic              wr_done;
	logic              rd_start;
	logic              rd_done;
	logic              wr_en;
	logic [idx_w-1:0]  wr_idx;
	logic [data_w-1:0] wr_data;
	logic [strb_w-1:0] wr_strb;
	logic              rd_en;
	logic [idx_w-1:0]  rd_idx;
	logic [data_w-1:0] rd_data;

	axi_mem_fsm #(
		.mem_words (mem_words)
	) i_fsm (
		.clk      (clk),
		.arst_n   (arst_n),
		.aw_valid (aw_valid),
		.aw_ready (aw_ready),
		.aw       (aw),
		.w_valid  (w_valid),
		.w_ready  (w_ready),
		.w        (w),
		.b_valid  (b_valid),
		.b_ready  (b_ready),
		.b        (b),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.ar       (ar),
		.r_valid  (r_valid),
		.r_ready  (r_ready),
		.r        (r),
		.wr_start (wr_start),
		.wr_done  (wr_done),
		.rd_start (rd_start),
		.rd_done  (rd_done),
		.wr_en    (wr_en),
		.wr_idx   (wr_idx),
		.wr_data  (wr_data),
		.wr_strb  (wr_strb),
		.rd_en    (rd_en),
		.rd_idx   (rd_idx),
		.rd_data  (rd_data)
	);

	// one timer per channel so reads and writes never wait on each other
	axi_mem_wait #(
		.wait_cycles (wait_cycles)
	) i_wr_wait (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (wr_start),
		.done   (wr_done)
	);

	axi_mem_wait #(
		.wait_cycles (wait_cycles)
	) i_rd_wait (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (rd_start),
		.done   (rd_done)
	);

	axi_mem_array #(
		.mem_words (mem_words)
	) i_array (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_data (wr_data),
		.wr_strb (wr_strb),
		.rd_en   (rd_en),
		.rd_idx  (rd_idx),
		.rd_data (rd_data)
	);

endmodule

`default_nettype wire

// ==== axi_mem_chk.sv ====
// Handshake checker for the AXI memory slave, bound into the top level.
// Flags a b or r response that drops or changes before its ready,
// write address and write data readiness that differ, and any valid
// output while reset is held.

`timescale 1ns/10ps
`default_nettype none

module axi_mem_chk (
	input logic                 clk,
	input logic                 arst_n,
	input logic                 aw_ready,
	input logic                 w_ready,
	input logic                 b_valid,
	input logic                 b_ready,
	input axi_mem_pkg::b_resp_t b,
	input logic                 r_valid,
	input logic                 r_ready,
	input axi_mem_pkg::r_beat_t r
);

	// a pending response holds until its ready
	b_held: assert property (@(posedge clk) disable iff (!arst_n)
		b_valid && !b_ready |=> b_valid && $stable(b))
		else $error("b response dropped or changed before b_ready");

	r_held: assert property (@(posedge clk) disable iff (!arst_n)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else $error("r response dropped or changed before r_ready");

	// address and data are taken on the same edge
	aw_w_ready: assert property (@(posedge clk) disable iff (!arst_n)
		aw_ready == w_ready)
		else $error("aw_ready and w_ready differ");

	quiet_in_reset: assert property (@(posedge clk)
		!arst_n |-> !b_valid && !r_valid)
		else $error("response valid high while reset is held");

endmodule

bind axi_mem_slave axi_mem_chk i_chk (.*);

`default_nettype wire

// ==== axi_mem_tb.sv ====
// Directed testbench for the AXI memory slave.
// Drives the five channels from tasks, keeps a word-level reference
// model with the strobe rule, and checks every response, its latency
// and its stability while ready is held low.

`timescale 1ns/10ps
`default_nettype none

module axi_mem_tb;
	import axi_mem_pkg::*;

	localparam int mem_words   = 64;
	localparam int wait_cycles = 2;
	localparam int clk_period  = 8;
	// transactions issued by all tests together
	localparam int n_trans     = 128 + 32 + 6 + 3 + 16 + 12;

	logic    clk;
	logic    arst_n;
	logic    aw_valid;
	logic    aw_ready;
	aw_req_t aw;
	logic    w_valid;
	logic    w_ready;
	w_beat_t w;
	logic    b_valid;
	logic    b_ready;
	b_resp_t b;
	logic    ar_valid;
	logic    ar_ready;
	ar_req_t ar;
	logic    r_valid;
	logic    r_ready;
	r_beat_t r;

	logic [data_w-1:0] model [mem_words];
	int                stall_max;

	axi_mem_slave #(
		.mem_words   (mem_words),
		.wait_cycles (wait_cycles)
	) i_dut (.*);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Verification failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_b(input string name, input b_resp_t got, input b_resp_t exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_r(input string name, input r_beat_t got, input r_beat_t exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_int(input string name, input int got, input int exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
		end
	endtask

	// strobed bytes replace the old ones
	function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old,
			input logic [data_w-1:0] data, input logic [strb_w-1:0] strb);
		logic [data_w-1:0] res;
		res = old;
		for (int i = 0; i < strb_w; i++) begin
			if (strb[i]) begin
				res[i*8 +: 8] = data[i*8 +: 8];
			end
		end
		return res;
	endfunction

	task automatic axi_write(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
			input logic [7:0] len, input logic [data_w-1:0] data,
			input logic [strb_w-1:0] strb, output b_resp_t got, output int acc);
		int   lat;
		int   stall;
		logic taken;
		@(negedge clk);
		aw_valid = 1'b1;
		aw       = aw_req_t'{id: id, addr: addr, len: len, size: 3'd3, burst: 2'b01};
		w_valid  = 1'b1;
		w        = w_beat_t'{data: data, strb: strb, last: 1'b1};
		// ready is settled in the low phase before the accepting edge
		do begin
			#(clk_period / 4);
			taken = aw_ready && w_ready;
			@(posedge clk);
			if (!taken) begin
				@(negedge clk);
			end
		end while (!taken);
		acc = int'($time / clk_period);
		@(negedge clk);
		aw_valid = 1'b0;
		w_valid  = 1'b0;
		// edges counted from acceptance
		lat = 0;
		while (!b_valid) begin
			@(negedge clk);
			lat++;
		end
		check_int("b_valid latency", lat, wait_cycles + 1);
		got   = b;
		stall = (stall_max > 0) ? $urandom_range(stall_max, 0) : 0;
		repeat (stall) begin
			@(negedge clk);
			check_int("b_valid held", b_valid, 1);
			check_b("b held", b, got);
		end
		b_ready = 1'b1;
		@(negedge clk);
		b_ready = 1'b0;
		check_int("b_valid after handshake", b_valid, 0);
	endtask

	task automatic axi_read(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
			input logic [7:0] len, output r_beat_t got, output int acc);
		int   lat;
		int   stall;
		logic taken;
		@(negedge clk);
		ar_valid = 1'b1;
		ar       = ar_req_t'{id: id, addr: addr, len: len, size: 3'd3, burst: 2'b01};
		do begin
			#(clk_period / 4);
			taken = ar_ready;
			@(posedge clk);
			if (!taken) begin
				@(negedge clk);
			end
		end while (!taken);
		acc = int'($time / clk_period);
		@(negedge clk);
		ar_valid = 1'b0;
		lat = 0;
		while (!r_valid) begin
			@(negedge clk);
			lat++;
		end
		check_int("r_valid latency", lat, wait_cycles + 1);
		got   = r;
		stall = (stall_max > 0) ? $urandom_range(stall_max, 0) : 0;
		repeat (stall) begin
			@(negedge clk);
			check_int("r_valid held", r_valid, 1);
			check_r("r held", r, got);
			check_int("ar_ready while r pending", ar_ready, 0);
		end
		r_ready = 1'b1;
		@(negedge clk);
		r_ready = 1'b0;
		check_int("r_valid after handshake", r_valid, 0);
		check_int("ar_ready after handshake", ar_ready, 1);
	endtask

	task automatic write_word(input int idx, input logic [data_w-1:0] data,
			input logic [strb_w-1:0] strb);
		logic [id_w-1:0] id;
		b_resp_t         got;
		int              acc;
		id = id_w'($urandom);
		axi_write(id, addr_w'(idx * strb_w), 8'd0, data, strb, got, acc);
		check_b("b", got, b_resp_t'{id: id, resp: resp_okay});
		model[idx] = merge_bytes(model[idx], data, strb);
	endtask

	task automatic read_word(input int idx);
		logic [id_w-1:0] id;
		r_beat_t         got;
		int              acc;
		id = id_w'($urandom);
		axi_read(id, addr_w'(idx * strb_w), 8'd0, got, acc);
		check_r("r", got, r_beat_t'{id: id, data: model[idx], resp: resp_okay, last: 1'b1});
	endtask

	task automatic test_fill();
		for (int i = 0; i < mem_words; i++) begin
			write_word(i, {$urandom, $urandom}, '1);
		end
		for (int i = 0; i < mem_words; i++) begin
			read_word(i);
		end
	endtask

	task automatic test_strobes();
		int idx;
		repeat (16) begin
			idx = $urandom_range(mem_words - 1, 0);
			write_word(idx, {$urandom, $urandom}, strb_w'($urandom));
			read_word(idx);
		end
	endtask

	// 512 aliases word 0 and the high address word 1
	task automatic test_out_of_range();
		logic [addr_w-1:0] bad [2];
		b_resp_t           bg;
		r_beat_t           rg;
		int                acc;
		bad[0] = 32'h0000_0200;
		bad[1] = 32'h1000_0008;
		foreach (bad[i]) begin
			axi_write(4'h9, bad[i], 8'd0, {$urandom, $urandom}, '1, bg, acc);
			check_b("b decerr", bg, b_resp_t'{id: 4'h9, resp: resp_decerr});
			axi_read(4'h6, bad[i], 8'd0, rg, acc);
			check_r("r decerr", rg, r_beat_t'{id: 4'h6, data: '0, resp: resp_decerr, last: 1'b1});
		end
		read_word(0);
		read_word(1);
	endtask

	task automatic test_burst_refused();
		b_resp_t bg;
		r_beat_t rg;
		int      acc;
		axi_write(4'h3, addr_w'(5 * strb_w), 8'd3, {$urandom, $urandom}, '1, bg, acc);
		check_b("b slverr", bg, b_resp_t'{id: 4'h3, resp: resp_slverr});
		read_word(5);
		axi_read(4'hc, addr_w'(5 * strb_w), 8'd1, rg, acc);
		check_r("r slverr", rg, r_beat_t'{id: 4'hc, data: '0, resp: resp_slverr, last: 1'b1});
	endtask

	task automatic test_backpressure();
		int idx;
		stall_max = 6;
		repeat (8) begin
			idx = $urandom_range(mem_words - 1, 0);
			write_word(idx, {$urandom, $urandom}, strb_w'($urandom));
			read_word(idx);
		end
		stall_max = 0;
	endtask

	task automatic test_concurrent();
		int                wi;
		int                ri;
		int                w_acc;
		int                r_acc;
		logic [data_w-1:0] data;
		b_resp_t           bg;
		r_beat_t           rg;
		repeat (4) begin
			wi   = $urandom_range(mem_words - 1, 0);
			ri   = (wi + 1 + $urandom_range(mem_words - 2, 0)) % mem_words;
			data = {$urandom, $urandom};
			fork
				axi_write(4'h1, addr_w'(wi * strb_w), 8'd0, data, '1, bg, w_acc);
				axi_read(4'h2, addr_w'(ri * strb_w), 8'd0, rg, r_acc);
			join
			check_b("b concurrent", bg, b_resp_t'{id: 4'h1, resp: resp_okay});
			check_r("r concurrent", rg,
				r_beat_t'{id: 4'h2, data: model[ri], resp: resp_okay, last: 1'b1});
			check_int("accept cycle of ar against aw", r_acc, w_acc);
			model[wi] = data;
			read_word(wi);
		end
	endtask

	initial begin
		#(longint'(n_trans) * 200 * clk_period + 10 * clk_period);
		abort_run("timeout: the tests did not finish in the allowed time");
	end

	initial begin
		void'($urandom(32'h49ce_7525));
		arst_n    = 1'b0;
		aw_valid  = 1'b0;
		aw        = '0;
		w_valid   = 1'b0;
		w         = '0;
		b_ready   = 1'b0;
		ar_valid  = 1'b0;
		ar        = '0;
		r_ready   = 1'b0;
		stall_max = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		test_fill();
		test_strobes();
		test_out_of_range();
		test_burst_refused();
		test_backpressure();
		test_concurrent();
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
axi_mem_pkg.sv
axi_mem_wait.sv
axi_mem_array.sv
axi_mem_fsm.sv
axi_mem_slave.sv
axi_mem_chk.sv
axi_mem_tb.sv
